/* rtg_video_top.f */
+incdir+design
design/rtg_cfg_pkg.sv
design/video_pkg.sv
design/rtg_regs.sv
design/rtg_blank_gen.sv
design/rtg_pixel_timer.sv
design/rtg_pixel_decode.sv
design/video_mixer.sv
design/rtg_video_top.sv
dv/tb_rtg_video.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_rtg_video \
	-f rtg_video_top.f -o sim_rtg_video \
	&& ./obj_dir/sim_rtg_video > sim.log 2>&1 \
	|| echo "Build or simulation returned an error"
grep -qsx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* dv/tb_rtg_video.sv */
// Testbench for the RTG video output stage with directed tests and checks
`timescale 1ns/100ps
`include "rtg_video_settings.svh"

module tb_rtg_video
	import rtg_cfg_pkg::*, video_pkg::*;
();

	logic                       CLK_114;
	logic                       reset;
	logic                       cfg_valid;
	logic                       cfg_ready;
	cfg_reg_e                   cfg_addr;
	logic [`RTG_CFG_DATA_W-1:0] cfg_data;
	pix_word_t                  pix_data;
	logic                       pix_valid;
	logic                       pix_ready;
	logic                       stream_rewind;
	chan_t                      chip_r;
	chan_t                      chip_g;
	chan_t                      chip_b;
	logic                       chip_hs;
	logic                       chip_vs;
	logic                       chip_cs;
	logic                       hblank;
	logic                       vblank;
	logic                       osd_window;
	logic                       osd_pixel;
	chan_t                      vga_r;
	chan_t                      vga_g;
	chan_t                      vga_b;
	logic                       vga_hs;
	logic                       vga_vs;
	logic                       vga_cs;

	int unsigned cycle; // Rising edges seen by the test process
	int unsigned xfer_cycle; // Edge of the last accepted word
	logic [23:0] clut_model [256]; // Palette as written

	rtg_video_top dut_i (.*);

	initial begin
		CLK_114 = 1'b0;
		forever #20 CLK_114 = ~CLK_114; // 40 ns period
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("Fail %s got %h expected %h", name, actual, expected));
		end
	endtask

	task automatic tick();
		@(posedge CLK_114);
		cycle++;
		#2; // Drive point
	endtask

	// 5-bit field followed by its top three bits
	function automatic logic [7:0] widen5(input logic [4:0] field);
		return {field, field[4:2]};
	endfunction

	function automatic logic [7:0] with_osd(input logic [7:0] chan, input logic pixel,
			input logic blue_chan);
		logic [1:0] top;
		if (pixel) begin
			top = 2'b11;
		end else begin
			top = blue_chan ? 2'b10 : 2'b00; // Dark blue background
		end
		return {top, chan[7:2]};
	endfunction

	task automatic compare_rgb(input logic [23:0] rgb);
		check_value("vga_r", 32'(vga_r), 32'(rgb[23:16]));
		check_value("vga_g", 32'(vga_g), 32'(rgb[15:8]));
		check_value("vga_b", 32'(vga_b), 32'(rgb[7:0]));
	endtask

	task automatic shows_direct(input pix_word_t word);
		compare_rgb({widen5(word[14:10]), widen5(word[9:5]), widen5(word[4:0])});
	endtask

	task automatic shows_blank();
		check_value("pix_ready", 32'(pix_ready), 32'd0);
		compare_rgb(24'h000000);
	endtask

	task automatic write_cfg(input cfg_reg_e addr, input logic [23:0] data);
		int unsigned waited = 0;
		cfg_valid = 1'b1;
		cfg_addr  = addr;
		cfg_data  = data;
		while (!cfg_ready) begin
			if (waited == 50) begin
				abort_run("Timeout, the config port never became ready");
			end
			tick();
			waited++;
		end
		tick(); // Write taken on this edge
		cfg_valid = 1'b0;
	endtask

	task automatic accept_word(input pix_word_t word);
		int unsigned waited = 0;
		pix_data  = word;
		pix_valid = 1'b1;
		#1; // Let pix_ready settle
		while (!pix_ready) begin
			if (waited == 100) begin
				abort_run("Timeout, the pixel stream never became ready");
			end
			tick();
			waited++;
		end
		tick();
		xfer_cycle = cycle;
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic passthrough_test();
		logic [23:0] rgb;
		logic [23:0] prev = '0;
		logic [2:0]  syncs;
		repeat (20) begin
			rgb   = 24'($urandom);
			syncs = 3'($urandom);
			{chip_r, chip_g, chip_b}    = rgb;
			{chip_hs, chip_vs, chip_cs} = syncs;
			#1;
			compare_rgb(prev); // Not through yet
			tick();
			compare_rgb(rgb);
			check_value("vga_syncs", 32'({vga_hs, vga_vs, vga_cs}), 32'(syncs));
			check_value("pix_ready", 32'(pix_ready), 32'd0);
			prev = rgb;
		end
		chip_hs = 1'b0;
		vblank  = 1'b1; // No rewind while RTG is off
		#1;
		check_value("stream_rewind", 32'(stream_rewind), 32'd0);
		tick();
		vblank = 1'b0;
	endtask

	task automatic direct_pace_test();
		pix_word_t   word;
		int unsigned last;
		write_cfg(REG_PIXWIDTH, 24'd3);
		write_cfg(REG_CTRL, 24'h000001); // Enable, direct colour
		accept_word(pix_word_t'($urandom));
		last = xfer_cycle;
		repeat (8) begin
			word = pix_word_t'($urandom);
			accept_word(word);
			check_value("xfer_gap", xfer_cycle - last, 32'd4);
			last = xfer_cycle;
			repeat (3) begin
				tick();
				shows_direct(word); // Held for the whole pixel
			end
		end
	endtask

	task automatic stall_test();
		pix_word_t   word;
		int unsigned start;
		word = pix_word_t'($urandom);
		accept_word(word);
		pix_valid = 1'b0; // Source runs dry
		repeat (3) begin
			tick();
			shows_direct(word);
		end
		repeat (6) begin
			tick();
			shows_direct(word);
			check_value("pix_ready", 32'(pix_ready), 32'd1);
		end
		start = cycle;
		word  = pix_word_t'($urandom);
		accept_word(word);
		check_value("xfer_cycle", xfer_cycle, start + 1); // Taken at once
		tick();
		shows_direct(word);
	endtask

	task automatic clut_test();
		pix_word_t   word;
		logic [23:0] entry;
		write_cfg(REG_CLUT_IDX, 24'h0000a5); // Pointer starts mid palette and wraps
		for (int i = 0; i < 256; i++) begin
			entry                    = 24'($urandom);
			clut_model[8'(i + 'ha5)] = entry;
			write_cfg(REG_CLUT_DATA, entry);
		end
		write_cfg(REG_PIXWIDTH, 24'd7); // Half width 3
		write_cfg(REG_CTRL, 24'h000003); // Enable, CLUT mode
		repeat (8) begin
			word = pix_word_t'($urandom);
			accept_word(word);
			tick();
			compare_rgb(clut_model[word[15:8]]); // Left pixel
			repeat (5) tick(); // Byte select and its delay
			compare_rgb(clut_model[word[7:0]]); // Right pixel
		end
	endtask

	task automatic blank_test();
		pix_word_t   word;
		int unsigned start;
		write_cfg(REG_PIXWIDTH, 24'd3);
		write_cfg(REG_CTRL, 24'h000001);
		write_cfg(REG_VBEND, 24'd3);
		vblank = 1'b1;
		#1;
		check_value("stream_rewind", 32'(stream_rewind), 32'd1);
		tick();
		check_value("stream_rewind", 32'(stream_rewind), 32'd1);
		check_value("pix_ready", 32'(pix_ready), 32'd0);
		vblank = 1'b0;
		#1;
		check_value("stream_rewind", 32'(stream_rewind), 32'd0);
		for (int line = 0; line < 3; line++) begin
			repeat (3) begin
				tick();
				shows_blank();
			end
			chip_hs = 1'b1; // Rising edge counted on next clock
			tick();
			shows_blank();
			chip_hs = 1'b0;
		end
		start = cycle; // Counter now at vbend
		word  = pix_word_t'($urandom);
		accept_word(word);
		check_value("xfer_cycle", xfer_cycle, start + 5);
		tick();
		shows_direct(word);

		hblank = 1'b1;
		#1;
		check_value("pix_ready", 32'(pix_ready), 32'd0);
		repeat (3) begin
			tick();
			shows_blank();
		end
		hblank = 1'b0;
		word = pix_word_t'($urandom);
		accept_word(word);
		tick();
		shows_direct(word);
	endtask

	task automatic osd_test();
		logic [23:0] rgb;
		pix_word_t   word;
		write_cfg(REG_CTRL, 24'h000000); // Back to chipset video
		osd_window = 1'b1;
		repeat (10) begin
			rgb = 24'($urandom);
			{chip_r, chip_g, chip_b} = rgb;
			osd_pixel = 1'($urandom);
			tick();
			compare_rgb({with_osd(rgb[23:16], osd_pixel, 1'b0),
				with_osd(rgb[15:8], osd_pixel, 1'b0), with_osd(rgb[7:0], osd_pixel, 1'b1)});
		end
		write_cfg(REG_CTRL, 24'h000001);
		word = pix_word_t'($urandom);
		accept_word(word);
		tick();
		repeat (4) begin
			osd_pixel = ~osd_pixel;
			#1;
			compare_rgb({with_osd(widen5(word[14:10]), osd_pixel, 1'b0),
				with_osd(widen5(word[9:5]), osd_pixel, 1'b0),
				with_osd(widen5(word[4:0]), osd_pixel, 1'b1)});
		end
		osd_window = 1'b0;
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		void'($urandom(32'h21bc_9a6e));
		cycle      = 0;
		xfer_cycle = 0;
		reset      = 1'b1;
		cfg_valid  = 1'b0;
		cfg_addr   = REG_CTRL;
		cfg_data   = '0;
		pix_data   = '0;
		pix_valid  = 1'b0;
		{chip_r, chip_g, chip_b}    = 24'hc35aa5; // Kept off vga by reset
		{chip_hs, chip_vs, chip_cs} = 3'b111;
		hblank     = 1'b0;
		vblank     = 1'b0;
		osd_window = 1'b0;
		osd_pixel  = 1'b0;
		repeat (4) tick();
		check_value("cfg_ready", 32'(cfg_ready), 32'd0); // Held off in reset
		reset = 1'b0;
		{chip_r, chip_g, chip_b}    = '0;
		{chip_hs, chip_vs, chip_cs} = 3'b000;
		compare_rgb(24'h000000); // Outputs cleared by reset
		check_value("vga_syncs", 32'({vga_hs, vga_vs, vga_cs}), 32'd0);
		check_value("pix_ready", 32'(pix_ready), 32'd0);
		tick();
		check_value("cfg_ready", 32'(cfg_ready), 32'd1);
		passthrough_test();
		direct_pace_test();
		stall_test();
		clut_test();
		blank_test();
		osd_test();
		$display("Simulation passed");
		$finish;
	end

endmodule

/* design/rtg_video_top.sv */
// Top level of the RTG display output stage, instances and wires
`timescale 1ns/100ps
`include "rtg_video_settings.svh"

module rtg_video_top
	import rtg_cfg_pkg::*, video_pkg::*;
(
	input  logic                       CLK_114,
	input  logic                       reset,
	input  logic                       cfg_valid,
	output logic                       cfg_ready,
	input  cfg_reg_e                   cfg_addr,
	input  logic [`RTG_CFG_DATA_W-1:0] cfg_data,
	input  pix_word_t                  pix_data,
	input  logic                       pix_valid,
	output logic                       pix_ready,
	output logic                       stream_rewind,
	input  chan_t                      chip_r,
	input  chan_t                      chip_g,
	input  chan_t                      chip_b,
	input  logic                       chip_hs,
	input  logic                       chip_vs,
	input  logic                       chip_cs,
	input  logic                       hblank,
	input  logic                       vblank,
	input  logic                       osd_window,
	input  logic                       osd_pixel,
	output chan_t                      vga_r,
	output chan_t                      vga_g,
	output chan_t                      vga_b,
	output logic                       vga_hs,
	output logic                       vga_vs,
	output logic                       vga_cs
);

	logic                  rtg_ena;
	color_mode_e           color_mode;
	logic                  rtg_ext;
	logic [`RTG_PW_W-1:0]  pixel_width;
	logic [`RTG_VB_W-1:0]  vbend;
	logic [`RTG_IDX_W-1:0] clut_idx;
	clut_entry_t           clut_rgb;
	logic                  blank;
	logic                  blank_d;
	logic                  byte_sel;
	chan_t                 rtg_r;
	chan_t                 rtg_g;
	chan_t                 rtg_b;

	rtg_regs regs_i (
		.CLK_114, .reset, .cfg_valid, .cfg_ready, .cfg_addr, .cfg_data,
		.rtg_ena, .color_mode, .rtg_ext, .pixel_width, .vbend,
		.clut_idx, .clut_rgb
	);

	rtg_blank_gen blank_gen_i (
		.CLK_114, .reset, .rtg_ena, .vblank, .hblank, .chip_hs, .vbend,
		.blank, .blank_d, .stream_rewind
	);

	rtg_pixel_timer pixel_timer_i (
		.CLK_114, .reset, .rtg_ena, .rtg_ext, .pixel_width, .blank, .blank_d,
		.pix_valid, .pix_ready, .byte_sel
	);

	rtg_pixel_decode pixel_decode_i (
		.CLK_114, .reset, .pix_data, .pix_valid, .pix_ready, .byte_sel,
		.color_mode, .clut_idx, .clut_rgb, .rtg_r, .rtg_g, .rtg_b
	);

	video_mixer mixer_i (
		.CLK_114, .reset, .rtg_ena, .blank, .rtg_r, .rtg_g, .rtg_b,
		.chip_r, .chip_g, .chip_b, .chip_hs, .chip_vs, .chip_cs,
		.osd_window, .osd_pixel,
		.vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs, .vga_cs
	);

endmodule

/* design/video_mixer.sv */
// RTG or chipset colour select, output registers and OSD overlay
`timescale 1ns/100ps
`include "rtg_video_settings.svh"

module video_mixer
	import video_pkg::*;
(
	input  logic  CLK_114,
	input  logic  reset,
	input  logic  rtg_ena,
	input  logic  blank,
	input  chan_t rtg_r,
	input  chan_t rtg_g,
	input  chan_t rtg_b,
	input  chan_t chip_r,
	input  chan_t chip_g,
	input  chan_t chip_b,
	input  logic  chip_hs,
	input  logic  chip_vs,
	input  logic  chip_cs,
	input  logic  osd_window,
	input  logic  osd_pixel,
	output chan_t vga_r,
	output chan_t vga_g,
	output chan_t vga_b,
	output logic  vga_hs,
	output logic  vga_vs,
	output logic  vga_cs
);

	chan_t      red_q;
	chan_t      green_q;
	chan_t      blue_q;
	logic [1:0] osd_r; // OSD top bits
	logic [1:0] osd_g;
	logic [1:0] osd_b;

	////////////////////////////////////////
	// Output register stage
	////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			{red_q, green_q, blue_q} <= '0;
			{vga_hs, vga_vs, vga_cs} <= 3'b000;
		end else begin
			vga_hs <= chip_hs;
			vga_vs <= chip_vs;
			vga_cs <= chip_cs;
			if (rtg_ena && !blank) begin
				{red_q, green_q, blue_q} <= {rtg_r, rtg_g, rtg_b};
			end else if (rtg_ena) begin
				{red_q, green_q, blue_q} <= '0; // RTG border is black
			end else begin
				{red_q, green_q, blue_q} <= {chip_r, chip_g, chip_b};
			end
		end
	end

	// White text on dark blue
	assign osd_r = osd_pixel ? 2'b11 : 2'b00;
	assign osd_g = osd_pixel ? 2'b11 : 2'b00;
	assign osd_b = osd_pixel ? 2'b11 : 2'b10;

	// Picture shifted down two bits shows through the OSD
	assign vga_r = osd_window ? {osd_r, red_q[`RTG_CHAN_W-1:2]} : red_q;
	assign vga_g = osd_window ? {osd_g, green_q[`RTG_CHAN_W-1:2]} : green_q;
	assign vga_b = osd_window ? {osd_b, blue_q[`RTG_CHAN_W-1:2]} : blue_q;

endmodule

/* design/rtg_pixel_decode.sv */
// Stream word hold register, 15-bit colour expansion and CLUT index lookup
`timescale 1ns/100ps
`include "rtg_video_settings.svh"

module rtg_pixel_decode
	import rtg_cfg_pkg::*, video_pkg::*;
(
	input  logic                  CLK_114,
	input  logic                  reset,
	input  pix_word_t             pix_data,
	input  logic                  pix_valid,
	input  logic                  pix_ready,
	input  logic                  byte_sel,
	input  color_mode_e           color_mode,
	output logic [`RTG_IDX_W-1:0] clut_idx,
	input  clut_entry_t           clut_rgb,
	output chan_t                 rtg_r,
	output chan_t                 rtg_g,
	output chan_t                 rtg_b
);

	pix_word_t word_q; // Last accepted word
	logic      byte_sel_d;
	chan_t     direct_r;
	chan_t     direct_g;
	chan_t     direct_b;

	////////////////////////////////////////
	// Word hold
	////////////////////////////////////////
	// Kept while the source stalls so the screen repeats the pixel
	always_ff @(posedge CLK_114) begin
		if (pix_valid && pix_ready) begin
			word_q <= pix_data;
		end
	end

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			byte_sel_d <= 1'b0;
		end else if (pix_valid && pix_ready) begin
			byte_sel_d <= 1'b0; // Restart on high byte of new word
		end else begin
			byte_sel_d <= byte_sel;
		end
	end

	// Indexed mode, high byte is the left pixel
	assign clut_idx = byte_sel_d ? word_q[7:0] : word_q[15:8];

	// Direct mode, x555
	assign direct_r = expand5(word_q[14:10]);
	assign direct_g = expand5(word_q[9:5]);
	assign direct_b = expand5(word_q[4:0]);

	always_comb begin
		if (color_mode == MODE_CLUT) begin
			rtg_r = clut_rgb[CLUT_R_LSB +: `RTG_CHAN_W];
			rtg_g = clut_rgb[CLUT_G_LSB +: `RTG_CHAN_W];
			rtg_b = clut_rgb[CLUT_B_LSB +: `RTG_CHAN_W];
		end else begin
			rtg_r = direct_r;
			rtg_g = direct_g;
			rtg_b = direct_b;
		end
	end

endmodule

/* design/rtg_pixel_timer.sv */
// Fetch pace counter, stream ready and CLUT byte select
`timescale 1ns/100ps
`include "rtg_video_settings.svh"

module rtg_pixel_timer (
	input  logic                 CLK_114,
	input  logic                 reset,
	input  logic                 rtg_ena,
	input  logic                 rtg_ext,
	input  logic [`RTG_PW_W-1:0] pixel_width,
	input  logic                 blank,
	input  logic                 blank_d,
	input  logic                 pix_valid,
	output logic                 pix_ready,
	output logic                 byte_sel
);

	logic [`RTG_PW_W-1:0] pix_cnt; // Clocks into current pixel
	logic [`RTG_PW_W-1:0] half_width;
	logic                 pix_xfer; // Word taken this cycle
	logic                 active; // Inside the fetch window

	assign half_width = {1'b0, pixel_width[`RTG_PW_W-1:1]}; // Rounded down
	assign active = !blank || (rtg_ext && !blank_d); // ext adds one clock
	assign pix_ready = rtg_ena && active && pix_cnt == pixel_width;
	assign pix_xfer = pix_valid & pix_ready;

	////////////////////////////////////////
	// Pace counter
	////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			pix_cnt  <= '0;
			byte_sel <= 1'b0;
		end else if (blank || pix_xfer) begin
			pix_cnt  <= '0; // New pixel starts
			byte_sel <= 1'b0; // High byte first
		end else begin
			if (pix_cnt == half_width) begin
				byte_sel <= 1'b1; // Second CLUT pixel
			end
			if (pix_cnt != pixel_width) begin
				pix_cnt <= pix_cnt + 1'b1;
			end
			// else source stalled, hold and keep ready up
		end
	end

	// Stream must stay idle while the RTG screen is off
	ready_needs_ena_a: assert property (@(posedge CLK_114) disable iff (reset)
		!rtg_ena |-> !pix_ready);

endmodule

/* design/rtg_blank_gen.sv */
// Vblank extension counter, combined blank with delayed copy, stream rewind
`timescale 1ns/100ps
`include "rtg_video_settings.svh"

module rtg_blank_gen (
	input  logic                 CLK_114,
	input  logic                 reset,
	input  logic                 rtg_ena,
	input  logic                 vblank,
	input  logic                 hblank,
	input  logic                 chip_hs,
	input  logic [`RTG_VB_W-1:0] vbend,
	output logic                 blank,
	output logic                 blank_d,
	output logic                 stream_rewind
);

	logic                 hs_d; // Previous hsync
	logic                 hs_rise;
	logic                 rtg_vblank; // Extended vertical blank
	logic [`RTG_VB_W-1:0] line_cnt; // Lines since chipset vblank

	assign hs_rise = chip_hs & ~hs_d;

	////////////////////////////////////////
	// Line counter after chipset vblank
	////////////////////////////////////////
	// The chipset vblank ends too early for RTG screens, so stretch it
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			hs_d       <= 1'b0;
			rtg_vblank <= 1'b0;
			line_cnt   <= '0;
			blank_d    <= 1'b0;
		end else begin
			hs_d    <= chip_hs;
			blank_d <= blank; // For the ext fetch
			if (vblank) begin
				rtg_vblank <= 1'b1;
				line_cnt   <= '0;
			end else if (line_cnt == vbend) begin
				rtg_vblank <= 1'b0; // End line reached
			end else if (hs_rise) begin
				line_cnt <= line_cnt + 1'b1;
			end
		end
	end

	assign blank = rtg_vblank | hblank;
	assign stream_rewind = vblank & rtg_ena; // Restart at frame base

endmodule

/* design/rtg_regs.sv */
// RTG mode registers, CLUT storage and its config write port
`timescale 1ns/100ps
`include "rtg_video_settings.svh"

module rtg_regs
	import rtg_cfg_pkg::*, video_pkg::*;
(
	input  logic                       CLK_114,
	input  logic                       reset,
	input  logic                       cfg_valid,
	output logic                       cfg_ready,
	input  cfg_reg_e                   cfg_addr,
	input  logic [`RTG_CFG_DATA_W-1:0] cfg_data,
	output logic                       rtg_ena,
	output color_mode_e                color_mode,
	output logic                       rtg_ext,
	output logic [`RTG_PW_W-1:0]       pixel_width,
	output logic [`RTG_VB_W-1:0]       vbend,
	input  logic [`RTG_IDX_W-1:0]      clut_idx,
	output clut_entry_t                clut_rgb
);

	logic                  cfg_wr; // Handshake completes
	logic [`RTG_IDX_W-1:0] clut_ptr; // Next CLUT entry to write
	clut_entry_t           clut_mem [`RTG_CLUT_DEPTH];

	assign cfg_wr = cfg_valid & cfg_ready;

	////////////////////////////////////////
	// Mode registers and write pointer
	////////////////////////////////////////
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			cfg_ready   <= 1'b0; // Held off until reset drops
			rtg_ena     <= 1'b0; // Chipset video shows
			color_mode  <= MODE_DIRECT;
			rtg_ext     <= 1'b0;
			pixel_width <= `RTG_PW_RESET;
			vbend       <= `RTG_VBEND_RESET;
			clut_ptr    <= '0;
		end else begin
			cfg_ready <= 1'b1; // One write per cycle from here on
			if (cfg_wr) begin
				case (cfg_addr)
					REG_CTRL: begin
						rtg_ena    <= cfg_data[0];
						color_mode <= color_mode_e'(cfg_data[1]);
						rtg_ext    <= cfg_data[2];
					end
					REG_PIXWIDTH:  pixel_width <= cfg_data[`RTG_PW_W-1:0];
					REG_VBEND:     vbend <= cfg_data[`RTG_VB_W-1:0];
					REG_CLUT_IDX:  clut_ptr <= cfg_data[`RTG_IDX_W-1:0];
					REG_CLUT_DATA: clut_ptr <= clut_ptr + 1'b1; // Walk through palette
					default: ;
				endcase
			end
		end
	end

	// Palette RAM, written at the pointer
	always_ff @(posedge CLK_114) begin
		if (cfg_wr && cfg_addr == REG_CLUT_DATA) begin
			clut_mem[clut_ptr] <= clut_entry_t'(cfg_data);
		end
	end

	assign clut_rgb = clut_mem[clut_idx]; // Async read for the decoder

	// Writer must not rely on pixel width bits the register drops
	pixwidth_fits_a: assert property (@(posedge CLK_114) disable iff (reset)
		cfg_wr && cfg_addr == REG_PIXWIDTH
			|-> cfg_data[`RTG_CFG_DATA_W-1:`RTG_PW_W] == '0);

endmodule

/* design/video_pkg.sv */
// Colour channel, stream word and CLUT entry types with 5-bit channel expansion
`include "rtg_video_settings.svh"

package video_pkg;

	typedef logic [`RTG_CHAN_W-1:0] chan_t; // One colour channel
	typedef logic [`RTG_PIX_W-1:0] pix_word_t; // Stream word
	typedef logic [3*`RTG_CHAN_W-1:0] clut_entry_t; // R, G, B from MSB down

	// Channel positions inside a CLUT entry
	localparam int CLUT_R_LSB = 2*`RTG_CHAN_W;
	localparam int CLUT_G_LSB = `RTG_CHAN_W;
	localparam int CLUT_B_LSB = 0;

	////////////////////////////////////////
	// 5-bit field to full channel
	////////////////////////////////////////
	// Top bits repeated into the bottom so full scale stays full scale
	function automatic chan_t expand5(input logic [4:0] field);
		chan_t chan;
		chan = {field, field[4:2]};
		return chan;
	endfunction

endpackage

/* design/rtg_cfg_pkg.sv */
// Configuration register map and colour mode types for the RTG screen
package rtg_cfg_pkg;

	////////////////////////////////////////
	// Register map of the config write port
	////////////////////////////////////////
	typedef enum logic [2:0] {
		REG_CTRL      = 3'd0, // [0] enable, [1] colour mode, [2] ext
		REG_PIXWIDTH  = 3'd1, // Clocks per fetch - 1
		REG_VBEND     = 3'd2, // Lines of vblank extension
		REG_CLUT_IDX  = 3'd3, // CLUT write pointer
		REG_CLUT_DATA = 3'd4  // Entry write, pointer auto increments
	} cfg_reg_e;

	////////////////////////////////////////
	// Colour mode of the RTG screen
	////////////////////////////////////////
	typedef enum logic {
		MODE_DIRECT = 1'b0, // 15-bit RGB, one pixel per word
		MODE_CLUT   = 1'b1  // Two 8-bit indexes per word
	} color_mode_e;

endpackage

/* design/rtg_video_settings.svh */
// Width, depth and reset value macros for the RTG video output stage
`ifndef RTG_VIDEO_SETTINGS_SVH
`define RTG_VIDEO_SETTINGS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////
`define RTG_CHAN_W      8       // One colour channel
`define RTG_PIX_W       16      // Stream word
`define RTG_PW_W        4       // Pixel width field, clocks per fetch - 1
`define RTG_VB_W        7       // Vblank end line field
`define RTG_CFG_DATA_W  24      // Config write data, one CLUT entry wide

// CLUT geometry
`define RTG_CLUT_DEPTH  256     // Entries
`define RTG_IDX_W       8       // Index into CLUT

// Reset values of the mode registers
`define RTG_PW_RESET    4'd0    // One clock per fetch
`define RTG_VBEND_RESET 7'd0    // No vblank extension

`endif
